//--- mpf_pkg.sv
package mpf_pkg;

    // ============================================================
    // Address geometry
    // ============================================================

    // Line offset bits within one page
    localparam int PAGE_BITS = 6;
    // Virtual page number bits, sized for the default 16 entry table
    localparam int VPN_BITS = 4;
    // Physical page number bits
    localparam int PPN_BITS = 12;

    // Virtual and physical line address widths
    localparam int VA_BITS = VPN_BITS + PAGE_BITS;
    localparam int PA_BITS = PPN_BITS + PAGE_BITS;

    // Client metadata and read data widths
    localparam int MDATA_BITS = 16;
    localparam int DATA_BITS = 64;

    // Memory port tag width. MAX_ACTIVE_REQS may not exceed 2**TAG_BITS
    localparam int TAG_BITS = 8;

    // ============================================================
    // Payloads
    // ============================================================

    // Read request from the client, 26 bits
    typedef struct packed {
        logic [VA_BITS-1:0]    addr;
        logic [MDATA_BITS-1:0] mdata;
    } mpf_req_t;

    // Read response toward the client, 80 bits
    typedef struct packed {
        logic [DATA_BITS-1:0]  data;
        logic [MDATA_BITS-1:0] mdata;
    } mpf_rsp_t;

endpackage

//--- mpf_req_fifo.sv
`timescale 1ns/1ps

// Valid/ready FIFO shared by the request and the response paths.
// The payload type is set per instance
module mpf_req_fifo
#(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    // Storage array, one entry written on each push
    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    // Pointer step with wrap, which also covers depths that are not a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Full holds the writer off; empty hides the output
    assign in_ready  = (count != CNT_BITS'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers and occupancy. A push and a pop in one cycle leave count unchanged
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- mpf_shim_rsp_order.sv
`timescale 1ns/1ps

// Read response sorter. Each request takes the tail slot, whose index
// becomes the memory tag. The client mdata waits in the slot and is
// joined back to the data when the head slot retires in request order
module mpf_shim_rsp_order
    import mpf_pkg::*;
#(
    parameter int MAX_ACTIVE_REQS = 8
)
(
    input  logic                 clk,
    input  logic                 reset,

    // Requests from the client side
    input  logic                 up_valid,
    input  mpf_req_t             up_req,
    output logic                 up_ready,

    // Tagged requests toward memory
    output logic                 dn_valid,
    output logic [VA_BITS-1:0]   dn_addr,
    output logic [TAG_BITS-1:0]  dn_tag,
    input  logic                 dn_ready,

    // Unordered responses from memory
    input  logic                 mem_rsp_valid,
    input  logic [TAG_BITS-1:0]  mem_rsp_tag,
    input  logic [DATA_BITS-1:0] mem_rsp_data,

    // Ordered responses toward the client
    output logic                 rsp_valid,
    output mpf_rsp_t             rsp,
    input  logic                 rsp_ready
);

    localparam int IDX_BITS = (MAX_ACTIVE_REQS > 1) ? $clog2(MAX_ACTIVE_REQS) : 1;
    localparam int CNT_BITS = $clog2(MAX_ACTIVE_REQS + 1);

    // ============================================================
    // Slot state
    // ============================================================

    logic [MDATA_BITS-1:0]      mdata_mem [MAX_ACTIVE_REQS];
    logic [DATA_BITS-1:0]       data_mem  [MAX_ACTIVE_REQS];
    // Set when a slot's data has come back from memory
    logic [MAX_ACTIVE_REQS-1:0] done;
    // Oldest outstanding slot and next slot to allocate
    logic [IDX_BITS-1:0]        head;
    logic [IDX_BITS-1:0]        tail;
    logic [CNT_BITS-1:0]        n_active;
    logic [IDX_BITS-1:0]        rsp_slot;
    logic                       slot_free;
    logic                       up_fire;
    logic                       rsp_fire;

    function automatic logic [IDX_BITS-1:0] next_idx(input logic [IDX_BITS-1:0] idx);
        if (idx == IDX_BITS'(MAX_ACTIVE_REQS - 1))
        begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    // ============================================================
    // Request side
    // ============================================================

    // A request flows straight through, but only while a slot is free
    assign slot_free = (n_active != CNT_BITS'(MAX_ACTIVE_REQS));
    assign dn_valid  = up_valid && slot_free;
    assign up_ready  = dn_ready && slot_free;
    assign dn_addr   = up_req.addr;
    // The slot index is the tag seen by memory
    assign dn_tag    = TAG_BITS'(tail);
    assign up_fire   = up_valid && up_ready;

    // ============================================================
    // Response side
    // ============================================================

    // Memory only returns tags of outstanding slots, so the low bits suffice
    assign rsp_slot  = mem_rsp_tag[IDX_BITS-1:0];

    // Head data shows the cycle after it lands, since done is registered
    assign rsp_valid  = done[head];
    assign rsp.data   = data_mem[head];
    assign rsp.mdata  = mdata_mem[head];
    assign rsp_fire   = rsp_valid && rsp_ready;

    // Slot payload, mdata on allocation and data on completion
    always_ff @(posedge clk)
    begin
        if (up_fire)
        begin
            mdata_mem[tail] <= up_req.mdata;
        end
        if (mem_rsp_valid)
        begin
            data_mem[rsp_slot] <= mem_rsp_data;
        end
    end

    // Allocation, completion and in-order retirement
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head     <= '0;
            tail     <= '0;
            n_active <= '0;
            done     <= '0;
        end
        else
        begin
            if (up_fire)
            begin
                tail <= next_idx(tail);
            end
            // The retiring head is already done, so it never matches a returning tag
            if (rsp_fire)
            begin
                done[head] <= 1'b0;
                head       <= next_idx(head);
            end
            if (mem_rsp_valid)
            begin
                done[rsp_slot] <= 1'b1;
            end
            case ({up_fire, rsp_fire})
                2'b10:   n_active <= n_active + 1'b1;
                2'b01:   n_active <= n_active - 1'b1;
                default: n_active <= n_active;
            endcase
        end
    end

endmodule

//--- mpf_shim_vtp.sv
`timescale 1ns/1ps

// Virtual to physical translation with a fully resident page table.
// With translation off the same register stage passes addresses through
module mpf_shim_vtp
    import mpf_pkg::*;
#(
    parameter int N_PAGES    = 16,
    parameter bit ENABLE_VTP = 1
)
(
    input  logic                clk,
    input  logic                reset,

    // Page table writes, always accepted
    input  logic                csr_wr_valid,
    input  logic [VPN_BITS-1:0] csr_wr_page,
    input  logic [PPN_BITS-1:0] csr_wr_ppn,

    // Virtual requests from the sorter
    input  logic                in_valid,
    input  logic [VA_BITS-1:0]  in_addr,
    input  logic [TAG_BITS-1:0] in_tag,
    output logic                in_ready,

    // Physical requests toward memory
    output logic                out_valid,
    output logic [PA_BITS-1:0]  out_addr,
    output logic [TAG_BITS-1:0] out_tag,
    input  logic                out_ready
);

    logic [PA_BITS-1:0] phys_addr;

    // ============================================================
    // Address mapping
    // ============================================================

    if (ENABLE_VTP)
    begin : vtp
        logic [PPN_BITS-1:0] page_table [N_PAGES];

        // The table comes out of reset as the identity map, so every page is valid
        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                for (int i = 0; i < N_PAGES; i++)
                begin
                    page_table[i] <= PPN_BITS'(i);
                end
            end
            else if (csr_wr_valid)
            begin
                page_table[csr_wr_page] <= csr_wr_ppn;
            end
        end

        // Physical page from the table, offset within the page unchanged
        assign phys_addr = {page_table[in_addr[VA_BITS-1:PAGE_BITS]],
                            in_addr[PAGE_BITS-1:0]};
    end
    else
    begin : no_vtp
        // No table, the virtual line is already physical
        assign phys_addr = PA_BITS'(in_addr);
    end

    // ============================================================
    // Output register
    // ============================================================

    // Take a new request when the register is empty or drains this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
        end
    end

    // Address and tag are payload and load with each accepted request
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            out_addr <= phys_addr;
            out_tag  <= in_tag;
        end
    end

endmodule

//--- mpf_pipe_std.sv
`timescale 1ns/1ps

// Read pipeline between the client and the memory port.
// Requests run down the file from the client, responses come back
// up through the sorter and leave through the response buffer
module mpf_pipe_std
    import mpf_pkg::*;
#(
    parameter int MAX_ACTIVE_REQS = 8,
    parameter int N_PAGES         = 16,
    parameter bit ENABLE_VTP      = 1,
    parameter int FIFO_DEPTH      = 4
)
(
    input  logic                  clk,
    input  logic                  reset,

    // Client requests
    input  logic                  req_valid,
    input  logic [VA_BITS-1:0]    req_addr,
    input  logic [MDATA_BITS-1:0] req_mdata,
    output logic                  req_ready,

    // Client responses
    output logic                  rsp_valid,
    output logic [DATA_BITS-1:0]  rsp_data,
    output logic [MDATA_BITS-1:0] rsp_mdata,
    input  logic                  rsp_ready,

    // Page table writes
    input  logic                  csr_wr_valid,
    input  logic [VPN_BITS-1:0]   csr_wr_page,
    input  logic [PPN_BITS-1:0]   csr_wr_ppn,

    // Memory requests
    output logic                  mem_req_valid,
    output logic [PA_BITS-1:0]    mem_req_addr,
    output logic [TAG_BITS-1:0]   mem_req_tag,
    input  logic                  mem_req_ready,

    // Memory responses, in any order and with no back-pressure
    input  logic                  mem_rsp_valid,
    input  logic [TAG_BITS-1:0]   mem_rsp_tag,
    input  logic [DATA_BITS-1:0]  mem_rsp_data
);

    // ============================================================
    // Stage 1. Client request buffer
    // ============================================================

    mpf_req_t client_req;
    mpf_req_t buf_req;
    logic     buf_req_valid;
    logic     buf_req_ready;

    assign client_req.addr  = req_addr;
    assign client_req.mdata = req_mdata;

    mpf_req_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (mpf_req_t)
    ) req_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (req_valid),
        .in_data   (client_req),
        .in_ready  (req_ready),
        .out_valid (buf_req_valid),
        .out_data  (buf_req),
        .out_ready (buf_req_ready)
    );

    // ============================================================
    // Stage 2. Response sorter and mdata store
    // ============================================================

    // The client's mdata stays here, memory only sees the slot tag
    logic                ord_valid;
    logic [VA_BITS-1:0]  ord_addr;
    logic [TAG_BITS-1:0] ord_tag;
    logic                ord_ready;
    mpf_rsp_t            ord_rsp;
    logic                ord_rsp_valid;
    logic                ord_rsp_ready;

    mpf_shim_rsp_order #(
        .MAX_ACTIVE_REQS (MAX_ACTIVE_REQS)
    ) rsp_order (
        .clk           (clk),
        .reset         (reset),
        .up_valid      (buf_req_valid),
        .up_req        (buf_req),
        .up_ready      (buf_req_ready),
        .dn_valid      (ord_valid),
        .dn_addr       (ord_addr),
        .dn_tag        (ord_tag),
        .dn_ready      (ord_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_data  (mem_rsp_data),
        .rsp_valid     (ord_rsp_valid),
        .rsp           (ord_rsp),
        .rsp_ready     (ord_rsp_ready)
    );

    // ============================================================
    // Stage 3. Address translation, the last stage before memory
    // ============================================================

    mpf_shim_vtp #(
        .N_PAGES    (N_PAGES),
        .ENABLE_VTP (ENABLE_VTP)
    ) v_to_p (
        .clk          (clk),
        .reset        (reset),
        .csr_wr_valid (csr_wr_valid),
        .csr_wr_page  (csr_wr_page),
        .csr_wr_ppn   (csr_wr_ppn),
        .in_valid     (ord_valid),
        .in_addr      (ord_addr),
        .in_tag       (ord_tag),
        .in_ready     (ord_ready),
        .out_valid    (mem_req_valid),
        .out_addr     (mem_req_addr),
        .out_tag      (mem_req_tag),
        .out_ready    (mem_req_ready)
    );

    // ============================================================
    // Stage 4. Client response buffer
    // ============================================================

    mpf_rsp_t client_rsp;

    mpf_req_fifo #(
        .DEPTH     (FIFO_DEPTH),
        .payload_t (mpf_rsp_t)
    ) rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ord_rsp_valid),
        .in_data   (ord_rsp),
        .in_ready  (ord_rsp_ready),
        .out_valid (rsp_valid),
        .out_data  (client_rsp),
        .out_ready (rsp_ready)
    );

    assign rsp_data  = client_rsp.data;
    assign rsp_mdata = client_rsp.mdata;

endmodule

//--- tb_mpf_pipe_std.sv
`timescale 1ns/1ps

module tb_mpf_pipe_std
    import mpf_pkg::*;
();

    localparam int          MAX_ACTIVE     = 8;
    localparam int          TIMEOUT_CYCLES = 2000;
    // Cycles of req_ready low that count as the pipeline being full
    localparam int          FULL_CYCLES    = 16;
    localparam logic [63:0] DATA_PATTERN   = 64'ha5c3_0f96_5a3c_f069;
    localparam logic [31:0] LFSR_SEED      = 32'h2010_86ba;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    logic [VA_BITS-1:0]    req_addr;
    logic [MDATA_BITS-1:0] req_mdata;
    logic                  req_ready;
    logic                  rsp_valid;
    logic [DATA_BITS-1:0]  rsp_data;
    logic [MDATA_BITS-1:0] rsp_mdata;
    logic                  rsp_ready;
    logic                  csr_wr_valid;
    logic [VPN_BITS-1:0]   csr_wr_page;
    logic [PPN_BITS-1:0]   csr_wr_ppn;
    logic                  mem_req_valid;
    logic [PA_BITS-1:0]    mem_req_addr;
    logic [TAG_BITS-1:0]   mem_req_tag;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    logic [TAG_BITS-1:0]   mem_rsp_tag;
    logic [DATA_BITS-1:0]  mem_rsp_data;

    // Expected values, in client request order
    logic [PA_BITS-1:0]    exp_mem_addr [$];
    logic [MDATA_BITS-1:0] exp_mdata [$];
    logic [DATA_BITS-1:0]  exp_data [$];
    // Requests taken by the memory model and not yet answered
    logic [TAG_BITS-1:0]   pend_tag [$];
    logic [PA_BITS-1:0]    pend_addr [$];

    logic [31:0] lfsr_state;
    logic        hold_rsp;
    logic        saw_full;
    int          full_cycles;

    mpf_pipe_std #(
        .MAX_ACTIVE_REQS (MAX_ACTIVE),
        .N_PAGES         (16),
        .ENABLE_VTP      (1),
        .FIFO_DEPTH      (4)
    ) i_mpf_pipe_std (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_mdata     (req_mdata),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .rsp_mdata     (rsp_mdata),
        .rsp_ready     (rsp_ready),
        .csr_wr_valid  (csr_wr_valid),
        .csr_wr_page   (csr_wr_page),
        .csr_wr_ppn    (csr_wr_ppn),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_data  (mem_rsp_data)
    );

    always #10 clk = ~clk;

    // ============================================================
    // Reporting and random bits
    // ============================================================

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // One Galois step yields one bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
        begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[6:0], lfsr_bit()};
        end
        return v;
    endfunction

    // ============================================================
    // Client and CSR drivers
    // ============================================================

    // Holds the request until the negedge shows req_ready, so it transfers on the next edge
    task automatic send_read(input logic [VA_BITS-1:0] addr,
                             input logic [MDATA_BITS-1:0] mdata,
                             input logic [PA_BITS-1:0] pline);
        int waited;
        waited = 0;
        req_valid = 1'b1;
        req_addr  = addr;
        req_mdata = mdata;
        @(negedge clk);
        while (!req_ready)
        begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
            begin
                report_error("req_ready stayed low and the read request was never accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        exp_mem_addr.push_back(pline);
        exp_mdata.push_back(mdata);
        exp_data.push_back(DATA_PATTERN ^ DATA_BITS'(pline));
    endtask

    task automatic write_page(input logic [VPN_BITS-1:0] page, input logic [PPN_BITS-1:0] ppn);
        csr_wr_valid = 1'b1;
        csr_wr_page  = page;
        csr_wr_ppn   = ppn;
        @(posedge clk);
        #1;
        csr_wr_valid = 1'b0;
    endtask

    // Waits until every issued read has come back to the client
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_mdata.size() != 0)
        begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
            begin
                report_error("outstanding reads did not drain back to the client");
            end
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    // ============================================================
    // Memory model and response sink
    // ============================================================

    // Handshakes are observed at the negedge, new values are driven 1 ns after the posedge
    initial
    begin : memory_model
        int pick;
        forever
        begin
            @(negedge clk);
            if (mem_req_valid && mem_req_ready)
            begin
                if (exp_mem_addr.size() == 0)
                begin
                    report_error("memory request seen with no client request behind it");
                end
                check_value("mem_req_addr", mem_req_addr, exp_mem_addr.pop_front());
                pend_tag.push_back(mem_req_tag);
                pend_addr.push_back(mem_req_addr);
                if (pend_tag.size() > MAX_ACTIVE)
                begin
                    report_error("more than 8 memory requests are outstanding");
                end
            end
            if (rsp_valid && rsp_ready)
            begin
                if (exp_mdata.size() == 0)
                begin
                    report_error("client response arrived with no read outstanding");
                end
                check_value("rsp_mdata", rsp_mdata, exp_mdata.pop_front());
                check_value("rsp_data", rsp_data, exp_data.pop_front());
            end
            // While responses are withheld the pipeline must fill and stop taking requests
            if (hold_rsp)
            begin
                if (req_ready === 1'b1)
                begin
                    full_cycles = 0;
                end
                else
                begin
                    full_cycles++;
                end
                if (full_cycles >= FULL_CYCLES)
                begin
                    check_value("outstanding memory requests", pend_tag.size(), MAX_ACTIVE);
                    hold_rsp = 1'b0;
                    saw_full = 1'b1;
                end
            end

            @(posedge clk);
            #1;
            mem_req_ready = (rand_bits(2) != 8'd0);
            rsp_ready     = lfsr_bit();
            mem_rsp_valid = 1'b0;
            // Answer a random pending request after a random gap
            if (!hold_rsp && pend_tag.size() != 0 && rand_bits(2) != 8'd0)
            begin
                pick          = rand_bits(3) % pend_tag.size();
                mem_rsp_valid = 1'b1;
                mem_rsp_tag   = pend_tag[pick];
                mem_rsp_data  = DATA_PATTERN ^ DATA_BITS'(pend_addr[pick]);
                pend_tag.delete(pick);
                pend_addr.delete(pick);
            end
        end
    end

    // ============================================================
    // Golden file replay
    // ============================================================

    initial
    begin : main_sequence
        int          fd;
        int          c;
        int          n;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;

        clk           = 1'b0;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req_addr      = '0;
        req_mdata     = '0;
        rsp_ready     = 1'b0;
        csr_wr_valid  = 1'b0;
        csr_wr_page   = '0;
        csr_wr_ppn    = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_tag   = '0;
        mem_rsp_data  = '0;
        lfsr_state    = LFSR_SEED;
        hold_rsp      = 1'b1;
        saw_full      = 1'b0;
        full_cycles   = 0;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("mpf_pipe_golden.txt", "r");
        if (fd == 0)
        begin
            report_error("cannot open mpf_pipe_golden.txt");
        end

        c = $fgetc(fd);
        while (c != -1)
        begin
            if (c == "W")
            begin
                n = $fscanf(fd, "%h %h", f1, f2);
                if (n != 2)
                begin
                    report_error("malformed W line in the golden file");
                end
                // Reads still in flight must see the old mapping
                wait_idle();
                write_page(f1[VPN_BITS-1:0], f2[PPN_BITS-1:0]);
            end
            else if (c == "R")
            begin
                n = $fscanf(fd, "%h %h %h", f1, f2, f3);
                if (n != 3)
                begin
                    report_error("malformed R line in the golden file");
                end
                send_read(f1[VA_BITS-1:0], f2[MDATA_BITS-1:0], f3[PA_BITS-1:0]);
            end
            else if (c == "#")
            begin
                while (c != "\n" && c != -1)
                begin
                    c = $fgetc(fd);
                end
            end
            else if (c != " " && c != "\n" && c != "\t" && c != "\r")
            begin
                report_error("unexpected character in the golden file");
            end
            c = $fgetc(fd);
        end
        $fclose(fd);

        wait_idle();
        // Once drained, a duplicated response or memory request would still be visible
        check_value("rsp_valid", rsp_valid, 1'b0);
        check_value("mem_req_valid", mem_req_valid, 1'b0);
        check_value("unchecked memory requests", exp_mem_addr.size(), 0);
        if (!saw_full)
        begin
            report_error("req_ready never dropped while memory withheld responses");
        end
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- filelist.f
mpf_pkg.sv
mpf_req_fifo.sv
mpf_shim_rsp_order.sv
mpf_shim_vtp.sv
mpf_pipe_std.sv
tb_mpf_pipe_std.sv

//--- Bender.yml
package:
  name: mpf_pipe_std

sources:
  - files:
      - mpf_pkg.sv
      - mpf_req_fifo.sv
      - mpf_shim_rsp_order.sv
      - mpf_shim_vtp.sv
      - mpf_pipe_std.sv
  - target: test
    files:
      - tb_mpf_pipe_std.sv

//--- mpf_pipe_golden.txt
# W <page> <ppn> : page table write, all fields hex
# R <vaddr> <mdata> <expected physical line> : read request, all fields hex
R 000 a000 00000
R 041 a001 00041
R 0c5 b3c2 000c5
R 13a 0007 0013a
R 1ff ffff 001ff
R 200 1234 00200
R 27f 5a5a 0027f
R 2c3 8001 002c3
R 355 4e21 00355
R 3ff c0de 003ff
R 010 0102 00010
R 0a8 7777 000a8
R 18c 9abc 0018c
R 31e 2468 0031e
# Remap pages 3, 9 and 0, the other pages keep the identity mapping
W 3 2a5
W 9 fff
W 0 100
R 0c5 d001 0a945
R 27f d002 3ffff
R 010 d003 04010
R 150 d004 00150
R 0c0 d005 0a940
R 3ff d006 003ff
R 240 d007 3ffc0
